/* verilog/mrdo_map_pkg.sv */
// main board memory map
`default_nettype none

package mrdo_map_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// memory sizes as address widths
	localparam int WORK_RAM_AW = 12;
	localparam int TILE_BANK_AW = 10;

	// region bases
	localparam logic [ADDR_W-1:0] TILE_RAM_BASE = 16'h8000;
	localparam logic [ADDR_W-1:0] FLIP_ADDR = 16'h9800;
	localparam logic [ADDR_W-1:0] PORT_BASE = 16'hA000;
	localparam logic [ADDR_W-1:0] WORK_RAM_BASE = 16'hE000;
	localparam logic [ADDR_W-1:0] SCROLL_BASE = 16'hF800;

	// open bus reads back as all ones
	localparam logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

	// decoded target of one access
	typedef enum logic [2:0] {
		REG_WORK_RAM,
		REG_TILE_RAM,
		REG_PORT,
		REG_SCROLL,
		REG_FLIP,
		REG_UNMAPPED
	} region_e;

	// tile ram bank, from address bits 11:10
	typedef enum logic [1:0] {
		BANK_BG_ATTR = 2'd0,
		BANK_BG_INDEX = 2'd1,
		BANK_FG_ATTR = 2'd2,
		BANK_FG_INDEX = 2'd3
	} tile_bank_e;

endpackage

`default_nettype wire

/* verilog/mrdo_bus_pkg.sv */
// bus and input types
`default_nettype none

package mrdo_bus_pkg;

	// one request from the external master
	typedef struct packed {
		logic [mrdo_map_pkg::ADDR_W-1:0] addr;
		logic wr;
		logic [mrdo_map_pkg::DATA_W-1:0] wdata;
	} bus_req_t;

	// access as seen by the targets
	typedef struct packed {
		logic [mrdo_map_pkg::ADDR_W-1:0] addr;
		logic [mrdo_map_pkg::DATA_W-1:0] data;
		logic wr;
		logic rd;
	} mem_wr_t;

	// player controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} joy_t;

	// four-phase slave states
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND,
		RELEASE
	} bus_state_e;

endpackage

`default_nettype wire

/* verilog/work_ram.sv */
// cpu work ram
`timescale 1ns/1ps
`default_nettype none

module work_ram (
	input wire logic clk_10M,
	input wire logic sel,
	input wire mrdo_bus_pkg::mem_wr_t acc,
	output logic [mrdo_map_pkg::DATA_W-1:0] rdata
);
	import mrdo_map_pkg::*;

	localparam int DEPTH = 1 << WORK_RAM_AW;

	logic [DATA_W-1:0] mem [0:DEPTH-1];
	logic [WORK_RAM_AW-1:0] offset;

	// E000-EFFF, low 12 bits pick the byte
	assign offset = acc.addr[WORK_RAM_AW-1:0];

	always_ff @(posedge clk_10M) begin
		if (sel && acc.wr) begin
			mem[offset] <= acc.data;
		end
		if (sel && acc.rd) begin
			rdata <= mem[offset];
		end
	end

endmodule

`default_nettype wire

/* verilog/tile_ram.sv */
// banked tile ram
`timescale 1ns/1ps
`default_nettype none

module tile_ram (
	input wire logic clk_10M,
	input wire logic sel,
	input wire mrdo_bus_pkg::mem_wr_t acc,
	output logic [mrdo_map_pkg::DATA_W-1:0] rdata
);
	import mrdo_map_pkg::*;

	localparam int DEPTH = 1 << TILE_BANK_AW;

	tile_bank_e bank;
	tile_bank_e bank_q;
	logic [TILE_BANK_AW-1:0] offset;
	logic [DATA_W-1:0] bank_rd [4];

	assign bank = tile_bank_e'(acc.addr[11:10]);
	assign offset = acc.addr[TILE_BANK_AW-1:0];

	// one 1k array per bank, writes steered by bank
	for (genvar b = 0; b < 4; b++) begin : g_bank
		logic [DATA_W-1:0] mem [0:DEPTH-1];

		always_ff @(posedge clk_10M) begin
			if (sel && acc.wr && bank == tile_bank_e'(b)) begin
				mem[offset] <= acc.data;
			end
			if (sel && acc.rd) begin
				bank_rd[b] <= mem[offset];
			end
		end
	end

	always_ff @(posedge clk_10M) begin
		if (sel && acc.rd) begin
			bank_q <= bank;
		end
	end

	// pick the bank that was read last
	always_comb begin
		case (bank_q)
			BANK_BG_ATTR: rdata = bank_rd[0];
			BANK_BG_INDEX: rdata = bank_rd[1];
			BANK_FG_ATTR: rdata = bank_rd[2];
			BANK_FG_INDEX: rdata = bank_rd[3];
			default: rdata = bank_rd[0];
		endcase
	end

	// a strobe into 8000-8FFF must come with the controller's select
	a_strobe_has_sel: assert property (@(posedge clk_10M)
		((acc.wr || acc.rd) && acc.addr[15:12] == TILE_RAM_BASE[15:12]) |-> sel);

endmodule

`default_nettype wire

/* verilog/io_regs.sv */
// input ports and video latches
`timescale 1ns/1ps
`default_nettype none

module io_regs (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire logic sel,
	input wire mrdo_bus_pkg::mem_wr_t acc,
	input wire mrdo_bus_pkg::joy_t joy,
	input wire logic [15:0] dip_sw,
	output logic [mrdo_map_pkg::DATA_W-1:0] rdata,
	output logic [mrdo_map_pkg::DATA_W-1:0] scroll_y,
	output logic flip_screen
);
	import mrdo_map_pkg::*;

	logic [DATA_W-1:0] p1;
	logic [DATA_W-1:0] p2;
	logic [DATA_W-1:0] dsw1;
	logic [DATA_W-1:0] dsw2;
	logic scroll_hit;
	logic flip_hit;

	// ports are active low on the board
	always_ff @(posedge clk_10M) begin
		p1 <= ~{1'b0, joy.start2, joy.start1, joy.fire, joy.up, joy.right, joy.down, joy.left};
		p2 <= ~{joy.coin, 2'b00, joy.fire, joy.up, joy.right, joy.down, joy.left};
		dsw1 <= dip_sw[7:0];
		dsw2 <= dip_sw[15:8];
	end

	// A000-A003
	always_ff @(posedge clk_10M) begin
		if (sel && acc.rd) begin
			case (acc.addr[1:0])
				2'd0: rdata <= p1;
				2'd1: rdata <= p2;
				2'd2: rdata <= dsw1;
				default: rdata <= dsw2;
			endcase
		end
	end

	// scroll latch mirrors over the whole of F800-FFFF
	assign scroll_hit = (acc.addr[15:11] == SCROLL_BASE[15:11]);
	assign flip_hit = (acc.addr == FLIP_ADDR);

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			scroll_y <= '0;
			flip_screen <= 1'b0;
		end else if (sel && acc.wr) begin
			if (scroll_hit) begin
				scroll_y <= acc.data;
			end
			if (flip_hit) begin
				flip_screen <= acc.data[0];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/mrdo_bus_ctrl.sv */
// four-phase bus slave
`timescale 1ns/1ps
`default_nettype none

module mrdo_bus_ctrl (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire logic req,
	input wire mrdo_bus_pkg::bus_req_t bus_req,
	output logic ack,
	output logic [mrdo_map_pkg::DATA_W-1:0] rdata,
	output mrdo_bus_pkg::mem_wr_t acc,
	output logic wram_sel,
	output logic tile_sel,
	output logic io_sel,
	input wire logic [mrdo_map_pkg::DATA_W-1:0] wram_rdata,
	input wire logic [mrdo_map_pkg::DATA_W-1:0] tile_rdata,
	input wire logic [mrdo_map_pkg::DATA_W-1:0] io_rdata
);
	import mrdo_map_pkg::*;
	import mrdo_bus_pkg::*;

	bus_state_e state;
	bus_req_t req_q;
	region_e region_d;
	region_e region_q;
	logic in_access;
	logic [DATA_W-1:0] rdata_d;

	// address decode on the live request, held from edge 1
	always_comb begin
		if (bus_req.addr[15:12] == WORK_RAM_BASE[15:12]) begin
			region_d = REG_WORK_RAM;
		end else if (bus_req.addr[15:12] == TILE_RAM_BASE[15:12]) begin
			region_d = REG_TILE_RAM;
		end else if (bus_req.addr[15:2] == PORT_BASE[15:2]) begin
			region_d = REG_PORT;
		end else if (bus_req.addr[15:11] == SCROLL_BASE[15:11]) begin
			region_d = REG_SCROLL;
		end else if (bus_req.addr == FLIP_ADDR) begin
			region_d = REG_FLIP;
		end else begin
			region_d = REG_UNMAPPED;
		end
	end

	// handshake
	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			state <= IDLE;
			ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= ACCESS;
					end
				end
				ACCESS: begin
					state <= RESPOND;
				end
				RESPOND: begin
					// ack goes up once, then we wait for req to drop
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						state <= RELEASE;
					end
				end
				RELEASE: begin
					ack <= 1'b0;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// request capture and read data return
	always_ff @(posedge clk_10M) begin
		if (state == IDLE && req) begin
			req_q <= bus_req;
			region_q <= region_d;
		end
		if (state == RESPOND && !ack) begin
			rdata <= rdata_d;
		end
	end

	// scroll and flip are write only, so they read as open bus
	always_comb begin
		case (region_q)
			REG_WORK_RAM: rdata_d = wram_rdata;
			REG_TILE_RAM: rdata_d = tile_rdata;
			REG_PORT: rdata_d = io_rdata;
			default: rdata_d = UNMAPPED_DATA;
		endcase
	end

	// one strobe for the single ACCESS cycle
	assign in_access = (state == ACCESS);

	always_comb begin
		acc.addr = req_q.addr;
		acc.data = req_q.wdata;
		acc.wr = in_access && req_q.wr;
		acc.rd = in_access && !req_q.wr;
	end

	assign wram_sel = in_access && (region_q == REG_WORK_RAM);
	assign tile_sel = in_access && (region_q == REG_TILE_RAM);
	assign io_sel = in_access && (region_q == REG_PORT || region_q == REG_SCROLL ||
		region_q == REG_FLIP);

	a_ack_needs_req: assert property (@(posedge clk_10M) disable iff (RESET)
		$rose(ack) |-> $past(req));

	a_sel_onehot: assert property (@(posedge clk_10M) disable iff (RESET)
		$onehot0({wram_sel, tile_sel, io_sel}));

	a_rdata_held: assert property (@(posedge clk_10M) disable iff (RESET)
		(ack && $past(ack)) |-> $stable(rdata));

endmodule

`default_nettype wire

/* verilog/mrdo_main_bus.sv */
// main board bus top
`timescale 1ns/1ps
`default_nettype none

module mrdo_main_bus (
	input wire logic clk_10M,
	input wire logic RESET,
	input wire logic req,
	input wire mrdo_bus_pkg::bus_req_t bus_req,
	output logic ack,
	output logic [7:0] rdata,
	input wire mrdo_bus_pkg::joy_t joy,
	input wire logic [15:0] dip_sw,
	output logic [7:0] scroll_y,
	output logic flip_screen
);
	import mrdo_map_pkg::*;
	import mrdo_bus_pkg::*;

	mem_wr_t acc;
	logic wram_sel;
	logic tile_sel;
	logic io_sel;
	logic [DATA_W-1:0] wram_rdata;
	logic [DATA_W-1:0] tile_rdata;
	logic [DATA_W-1:0] io_rdata;

	mrdo_bus_ctrl i_bus_ctrl (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.req(req),
		.bus_req(bus_req),
		.ack(ack),
		.rdata(rdata),
		.acc(acc),
		.wram_sel(wram_sel),
		.tile_sel(tile_sel),
		.io_sel(io_sel),
		.wram_rdata(wram_rdata),
		.tile_rdata(tile_rdata),
		.io_rdata(io_rdata)
	);

	work_ram i_work_ram (
		.clk_10M(clk_10M),
		.sel(wram_sel),
		.acc(acc),
		.rdata(wram_rdata)
	);

	tile_ram i_tile_ram (
		.clk_10M(clk_10M),
		.sel(tile_sel),
		.acc(acc),
		.rdata(tile_rdata)
	);

	io_regs i_io_regs (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.sel(io_sel),
		.acc(acc),
		.joy(joy),
		.dip_sw(dip_sw),
		.rdata(io_rdata),
		.scroll_y(scroll_y),
		.flip_screen(flip_screen)
	);

endmodule

`default_nettype wire

/* verif/tb_mrdo_main_bus.sv */
// main bus testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mrdo_main_bus;
	import mrdo_map_pkg::*;
	import mrdo_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;

	logic clk_10M;
	logic RESET;
	logic req;
	bus_req_t bus_req;
	logic ack;
	logic [7:0] rdata;
	joy_t joy;
	logic [15:0] dip_sw;
	logic [7:0] scroll_y;
	logic flip_screen;

	// reference map model
	logic [15:0] lfsr;
	logic [7:0] wram_model [0:4095];
	logic [7:0] tile_model [0:4095];
	logic [15:0] wram_addrs [$];
	logic [15:0] tile_addrs [$];
	logic [7:0] last_scroll;
	logic last_flip;
	int errors;
	bit timed_out;

	mrdo_main_bus i_dut (
		.clk_10M(clk_10M),
		.RESET(RESET),
		.req(req),
		.bus_req(bus_req),
		.ack(ack),
		.rdata(rdata),
		.joy(joy),
		.dip_sw(dip_sw),
		.scroll_y(scroll_y),
		.flip_screen(flip_screen)
	);

	initial begin
		clk_10M = 1'b0;
		forever #50 clk_10M = ~clk_10M;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_random_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[14:0], lfsr[0]};
		end
	endtask

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic drive_request(input logic wr, input logic [15:0] addr,
		input logic [7:0] wdata);
		bus_req.addr = addr;
		bus_req.wr = wr;
		bus_req.wdata = wdata;
		req = 1'b1;
	endtask

	// counts falling edges until ack is seen high
	task automatic wait_for_ack(output int cycles);
		cycles = 0;
		while (ack !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk_10M);
			cycles++;
		end
		if (ack !== 1'b1) begin
			$display("timeout: ack did not rise within %0d cycles at %0t ns",
				TIMEOUT_CYCLES, $time);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_release(output int cycles);
		cycles = 0;
		while (ack !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk_10M);
			cycles++;
		end
		if (ack !== 1'b0) begin
			$display("timeout: ack did not fall within %0d cycles at %0t ns",
				TIMEOUT_CYCLES, $time);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic bus_access(input logic wr, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] data);
		int cycles;
		drive_request(wr, addr, wdata);
		wait_for_ack(cycles);
		data = rdata;
		req = 1'b0;
		wait_for_release(cycles);
	endtask

	// read back every address written so far
	task automatic verify_memories();
		logic [7:0] data;
		for (int i = 0; i < wram_addrs.size(); i++) begin
			bus_access(1'b0, wram_addrs[i], 8'h00, data);
			compare_value("rdata (work ram)", wram_model[wram_addrs[i][11:0]], data);
		end
		for (int i = 0; i < tile_addrs.size(); i++) begin
			bus_access(1'b0, tile_addrs[i], 8'h00, data);
			compare_value("rdata (tile ram)", tile_model[tile_addrs[i][11:0]], data);
		end
	endtask

	task automatic run_case(input logic [8*16-1:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] expected);
		int cycles;
		logic [15:0] rnd;
		logic [15:0] a;
		logic [7:0] d;
		logic [7:0] got;
		case (op)
			"hs": begin
				compare_value("ack", 1'b0, ack);
				drive_request(1'b0, addr, 8'h00);
				wait_for_ack(cycles);
				compare_value("ack latency", 3, cycles);
				compare_value("rdata", expected, rdata);
				// master keeps req up, response must hold
				for (int i = 0; i < 5; i++) begin
					@(negedge clk_10M);
					compare_value("ack", 1'b1, ack);
					compare_value("rdata", expected, rdata);
				end
				req = 1'b0;
				wait_for_release(cycles);
				compare_value("ack release latency", 2, cycles);
			end
			"wram": begin
				// data column is the number of sampled addresses
				for (int i = 0; i < data; i++) begin
					take_random_bits(12, rnd);
					a = {WORK_RAM_BASE[15:12], rnd[11:0]};
					take_random_bits(8, rnd);
					d = rnd[7:0];
					bus_access(1'b1, a, d, got);
					wram_model[a[11:0]] = d;
					wram_addrs.push_back(a);
				end
				verify_memories();
			end
			"tile": begin
				// same offset in every bank, distinct data
				for (int b = 0; b < 4; b++) begin
					a = {TILE_RAM_BASE[15:12], b[1:0], addr[9:0]};
					d = data + {b[1:0], 6'd0};
					bus_access(1'b1, a, d, got);
					tile_model[a[11:0]] = d;
					tile_addrs.push_back(a);
				end
				verify_memories();
			end
			"port", "read": begin
				bus_access(1'b0, addr, 8'h00, got);
				compare_value("rdata", expected, got);
			end
			"scroll": begin
				drive_request(1'b1, addr, data);
				wait_for_ack(cycles);
				compare_value("scroll_y", expected, scroll_y);
				compare_value("flip_screen", last_flip, flip_screen);
				req = 1'b0;
				wait_for_release(cycles);
				last_scroll = expected;
			end
			"flip": begin
				drive_request(1'b1, addr, data);
				wait_for_ack(cycles);
				compare_value("flip_screen", expected[0], flip_screen);
				compare_value("scroll_y", last_scroll, scroll_y);
				req = 1'b0;
				wait_for_release(cycles);
				last_flip = expected[0];
			end
			"write_unmapped": begin
				// ram bytes that share the low address bits with the write
				a = {WORK_RAM_BASE[15:12], addr[11:0]};
				bus_access(1'b1, a, ~data, got);
				wram_model[a[11:0]] = ~data;
				wram_addrs.push_back(a);
				a = {TILE_RAM_BASE[15:12], addr[11:0]};
				bus_access(1'b1, a, ~data, got);
				tile_model[a[11:0]] = ~data;
				tile_addrs.push_back(a);
				bus_access(1'b1, addr, data, got);
				compare_value("scroll_y", last_scroll, scroll_y);
				compare_value("flip_screen", last_flip, flip_screen);
				verify_memories();
			end
			default: begin
				$display("unknown operation %0s in cases file", op);
				errors++;
			end
		endcase
	endtask

	initial begin
		int fd;
		int fields;
		int test_num;
		int passed;
		int test_errors;
		logic [8*128-1:0] line;
		logic [8*16-1:0] op;
		logic [15:0] c_addr;
		logic [15:0] c_data;
		logic [15:0] c_joy;
		logic [15:0] c_dip;
		logic [15:0] c_exp;

		RESET = 1'b1;
		req = 1'b0;
		bus_req = '0;
		joy = '0;
		dip_sw = '0;
		lfsr = 16'd73;
		errors = 0;
		timed_out = 1'b0;
		test_num = 0;
		passed = 0;
		last_scroll = 8'h00;
		last_flip = 1'b0;
		repeat (10) @(negedge clk_10M);
		RESET = 1'b0;

		fd = $fopen("verif/mrdo_bus_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/mrdo_bus_cases.txt");
			errors++;
		end else begin
			while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					fields = $fgets(line, fd);
				end else begin
					fields = $fscanf(fd, "%h %h %h %h %h", c_addr, c_data, c_joy, c_dip, c_exp);
					if (fields != 5) begin
						$display("malformed line in cases file at operation %0s", op);
						errors++;
					end else begin
						test_errors = errors;
						test_num++;
						joy = c_joy[7:0];
						dip_sw = c_dip;
						run_case(op, c_addr, c_data[7:0], c_exp[7:0]);
						if (errors == test_errors) begin
							passed++;
						end
						$display("test %0d %0s %h: %s", test_num, op, c_addr,
							(errors == test_errors) ? "pass" : "FAIL");
					end
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d passed, %0d errors", test_num, passed, errors);
		if (errors == 0 && !timed_out && test_num > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/mrdo_bus_cases.txt */
# op addr data joy dip expect, all values hex
# wram takes data as sample count, tile takes data as fill base
hs A002 00 00 005A 5A
wram E000 40 00 0000 00
tile 8123 5A 00 0000 00
tile 83FF C7 00 0000 00
port A000 00 00 0000 FF
port A001 00 00 0000 FF
port A000 00 80 0000 F7
port A001 00 80 0000 F7
port A000 00 0F 0000 8F
port A001 00 0F 0000 6F
port A000 00 70 0000 F8
port A000 00 A5 0000 D6
port A001 00 A5 0000 76
port A002 00 00 C35A 5A
port A003 00 00 C35A C3
port A003 00 00 FFFF FF
scroll F800 3C 00 0000 3C
scroll FFFF C1 00 0000 C1
flip 9800 01 00 0000 01
flip 9800 FE 00 0000 00
read 0000 00 00 0000 FF
read 9000 00 00 0000 FF
read F000 00 00 0000 FF
write_unmapped 9000 A5 00 0000 00

/* mrdo_main_bus.f */
verilog/mrdo_map_pkg.sv
verilog/mrdo_bus_pkg.sv
verilog/work_ram.sv
verilog/tile_ram.sv
verilog/io_regs.sv
verilog/mrdo_bus_ctrl.sv
verilog/mrdo_main_bus.sv
verif/tb_mrdo_main_bus.sv
